//--- rtl/mem_access_pkg.sv
`default_nettype none

package mem_access_pkg;

   localparam int ADDR_W = 32;
   localparam int SIZE_W = 4;
   localparam int DATA_W = 64;
   localparam int BYTES_PER_WORD = DATA_W / 8;

   // Only the low address bits reach the byte array
   localparam int MEM_ADDR_BITS = 8;
   localparam int MEM_BYTES = 1 << MEM_ADDR_BITS;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [SIZE_W-1:0] size_t;

   // Little-endian, byte 0 sits at the access address
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [BYTES_PER_WORD-1:0] byte_en_t;
   typedef logic [MEM_ADDR_BITS-1:0] mem_idx_t;

endpackage

`default_nettype wire

//--- rtl/pipe_op_pkg.sv
`default_nettype none

package pipe_op_pkg;

   localparam int OP_W = 3;

   // Each op decodes into up to two reads and up to two writes
   typedef enum logic [OP_W-1:0] {
      OP_NOP    = 3'd0,
      OP_LOAD   = 3'd1,
      OP_LOAD2  = 3'd2,
      OP_STORE  = 3'd3,
      OP_STORE2 = 3'd4,
      OP_COPY   = 3'd5
   } op_t;

endpackage

`default_nettype wire

//--- rtl/issue_stage.sv
`default_nettype none

module issue_stage (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          in_valid,
   input  wire pipe_op_pkg::op_t        op,
   input  wire mem_access_pkg::addr_t   addr_a,
   input  wire mem_access_pkg::addr_t   addr_b,
   input  wire mem_access_pkg::size_t   size,
   input  wire mem_access_pkg::data_t   wdata,
   input  wire                          stall,
   output logic                         in_ready,
   output logic                         issue_valid,
   output pipe_op_pkg::op_t             issue_op,
   output logic                         rd1_v,
   output logic                         rd2_v,
   output logic                         wr1_v,
   output logic                         wr2_v,
   output mem_access_pkg::addr_t        rd1_addr,
   output mem_access_pkg::addr_t        rd2_addr,
   output mem_access_pkg::addr_t        wr1_addr,
   output mem_access_pkg::addr_t        wr2_addr,
   output mem_access_pkg::size_t        issue_size,
   output mem_access_pkg::data_t        issue_wdata
);

   mem_access_pkg::addr_t addr_a_q;
   mem_access_pkg::addr_t addr_b_q;

   // Empty, or advancing into execute on this edge
   assign in_ready = !issue_valid || !stall;

   always_ff @(posedge clk) begin
      if (reset) begin
         issue_valid <= 1'b0;
      end else if (in_ready) begin
         issue_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_ready && in_valid) begin
         issue_op    <= op;
         addr_a_q    <= addr_a;
         addr_b_q    <= addr_b;
         issue_size  <= size;
         issue_wdata <= wdata;
      end
   end

   ////////////////////
   // Op decode

   assign rd1_addr = addr_a_q;
   assign rd2_addr = addr_b_q;
   assign wr2_addr = addr_b_q;

   // A copy lands at addr_b through write port 1
   assign wr1_addr = (issue_op == pipe_op_pkg::OP_COPY) ? addr_b_q : addr_a_q;

   always_comb begin
      rd1_v = 1'b0;
      rd2_v = 1'b0;
      wr1_v = 1'b0;
      wr2_v = 1'b0;
      case (issue_op)
         pipe_op_pkg::OP_LOAD: begin
            rd1_v = 1'b1;
         end
         pipe_op_pkg::OP_LOAD2: begin
            rd1_v = 1'b1;
            rd2_v = 1'b1;
         end
         pipe_op_pkg::OP_STORE: begin
            wr1_v = 1'b1;
         end
         pipe_op_pkg::OP_STORE2: begin
            wr1_v = 1'b1;
            wr2_v = 1'b1;
         end
         pipe_op_pkg::OP_COPY: begin
            rd1_v = 1'b1;
            wr1_v = 1'b1;
         end
         default: begin
            rd1_v = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/mem_dependency_check.sv
`default_nettype none

module mem_dependency_check (
   input  wire                          issue_valid,
   input  wire                          rd1_v,
   input  wire                          rd2_v,
   input  wire mem_access_pkg::addr_t   rd1_addr,
   input  wire mem_access_pkg::addr_t   rd2_addr,
   input  wire mem_access_pkg::size_t   rd_size,
   input  wire                          ex_valid,
   input  wire                          ex_wr1_v,
   input  wire                          ex_wr2_v,
   input  wire mem_access_pkg::addr_t   ex_wr1_addr,
   input  wire mem_access_pkg::addr_t   ex_wr2_addr,
   input  wire mem_access_pkg::size_t   ex_size,
   input  wire                          me_valid,
   input  wire                          me_wr1_v,
   input  wire                          me_wr2_v,
   input  wire mem_access_pkg::addr_t   me_wr1_addr,
   input  wire mem_access_pkg::addr_t   me_wr2_addr,
   input  wire mem_access_pkg::size_t   me_size,
   output logic                         stall
);

   mem_access_pkg::addr_t rd_start [2];
   mem_access_pkg::addr_t rd_end   [2];
   mem_access_pkg::addr_t wr_start [4];
   mem_access_pkg::addr_t wr_end   [4];
   logic                  rd_live  [2];
   logic                  wr_live  [4];
   logic                  rd_before_wr_end [2][4];
   logic                  wr_before_rd_end [2][4];

   ////////////////////
   // Range ends, plain 32-bit sums

   always_comb begin
      rd_start[0] = rd1_addr;
      rd_start[1] = rd2_addr;
      rd_end[0]   = rd1_addr + mem_access_pkg::addr_t'(rd_size);
      rd_end[1]   = rd2_addr + mem_access_pkg::addr_t'(rd_size);
      rd_live[0]  = issue_valid && rd1_v;
      rd_live[1]  = issue_valid && rd2_v;

      wr_start[0] = ex_wr1_addr;
      wr_start[1] = ex_wr2_addr;
      wr_start[2] = me_wr1_addr;
      wr_start[3] = me_wr2_addr;
      wr_end[0]   = ex_wr1_addr + mem_access_pkg::addr_t'(ex_size);
      wr_end[1]   = ex_wr2_addr + mem_access_pkg::addr_t'(ex_size);
      wr_end[2]   = me_wr1_addr + mem_access_pkg::addr_t'(me_size);
      wr_end[3]   = me_wr2_addr + mem_access_pkg::addr_t'(me_size);
      wr_live[0]  = ex_valid && ex_wr1_v;
      wr_live[1]  = ex_valid && ex_wr2_v;
      wr_live[2]  = me_valid && me_wr1_v;
      wr_live[3]  = me_valid && me_wr2_v;
   end

   ////////////////////
   // Overlap means each range starts before the other ends

   always_comb begin
      stall = 1'b0;
      for (int r = 0; r < 2; r++) begin
         for (int w = 0; w < 4; w++) begin
            rd_before_wr_end[r][w] = rd_start[r] < wr_end[w];
            wr_before_rd_end[r][w] = wr_start[w] < rd_end[r];
            if (rd_live[r] && wr_live[w] && rd_before_wr_end[r][w]
                  && wr_before_rd_end[r][w]) begin
               stall = 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/byte_mem.sv
`default_nettype none

module byte_mem (
   input  wire                            clk,
   input  wire                            reset,
   input  wire mem_access_pkg::addr_t     rd1_addr,
   input  wire mem_access_pkg::addr_t     rd2_addr,
   input  wire mem_access_pkg::size_t     rd_size,
   output mem_access_pkg::data_t          rd1_data,
   output mem_access_pkg::data_t          rd2_data,
   input  wire mem_access_pkg::byte_en_t  wr1_en,
   input  wire mem_access_pkg::byte_en_t  wr2_en,
   input  wire mem_access_pkg::addr_t     wr1_addr,
   input  wire mem_access_pkg::addr_t     wr2_addr,
   input  wire mem_access_pkg::data_t     wr1_data,
   input  wire mem_access_pkg::data_t     wr2_data
);

   logic [7:0] mem [mem_access_pkg::MEM_BYTES];

   // Collect bytes upward from addr, zero past the access size
   function automatic mem_access_pkg::data_t gather(
      input mem_access_pkg::addr_t addr,
      input mem_access_pkg::size_t size
   );
      mem_access_pkg::data_t    word;
      mem_access_pkg::mem_idx_t idx;
      word = '0;
      for (int i = 0; i < mem_access_pkg::BYTES_PER_WORD; i++) begin
         idx = addr[mem_access_pkg::MEM_ADDR_BITS-1:0] + mem_access_pkg::mem_idx_t'(i);
         if (i < int'(size)) begin
            word[8*i +: 8] = mem[idx];
         end
      end
      return word;
   endfunction

   always_comb begin
      rd1_data = gather(rd1_addr, rd_size);
      rd2_data = gather(rd2_addr, rd_size);
   end

   ////////////////////
   // Write ports

   // Port 2 is applied last, so its bytes win where the two overlap
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < mem_access_pkg::MEM_BYTES; i++) begin
            mem[i] <= 8'h00;
         end
      end else begin
         for (int i = 0; i < mem_access_pkg::BYTES_PER_WORD; i++) begin
            if (wr1_en[i]) begin
               mem[wr1_addr[mem_access_pkg::MEM_ADDR_BITS-1:0]
                   + mem_access_pkg::mem_idx_t'(i)] <= wr1_data[8*i +: 8];
            end
         end
         for (int i = 0; i < mem_access_pkg::BYTES_PER_WORD; i++) begin
            if (wr2_en[i]) begin
               mem[wr2_addr[mem_access_pkg::MEM_ADDR_BITS-1:0]
                   + mem_access_pkg::mem_idx_t'(i)] <= wr2_data[8*i +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/exec_stage.sv
`default_nettype none

module exec_stage (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          issue_valid,
   input  wire                          stall,
   input  wire pipe_op_pkg::op_t        issue_op,
   input  wire                          wr1_v,
   input  wire                          wr2_v,
   input  wire mem_access_pkg::addr_t   wr1_addr,
   input  wire mem_access_pkg::addr_t   wr2_addr,
   input  wire mem_access_pkg::size_t   issue_size,
   input  wire mem_access_pkg::data_t   issue_wdata,
   input  wire mem_access_pkg::data_t   rd1_data,
   input  wire mem_access_pkg::data_t   rd2_data,
   output logic                         ex_valid,
   output logic                         ex_wr1_v,
   output logic                         ex_wr2_v,
   output mem_access_pkg::addr_t        ex_wr1_addr,
   output mem_access_pkg::addr_t        ex_wr2_addr,
   output mem_access_pkg::size_t        ex_size,
   output mem_access_pkg::data_t        ex_wdata,
   output logic                         load_valid,
   output mem_access_pkg::data_t        load_data1,
   output mem_access_pkg::data_t        load_data2
);

   logic             advance;
   pipe_op_pkg::op_t ex_op;

   assign advance = issue_valid && !stall;

   // A stalled or empty issue stage leaves a bubble here
   always_ff @(posedge clk) begin
      if (reset) begin
         ex_valid <= 1'b0;
         ex_wr1_v <= 1'b0;
         ex_wr2_v <= 1'b0;
      end else begin
         ex_valid <= advance;
         ex_wr1_v <= advance && wr1_v;
         ex_wr2_v <= advance && wr2_v;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         ex_op       <= issue_op;
         ex_wr1_addr <= wr1_addr;
         ex_wr2_addr <= wr2_addr;
         ex_size     <= issue_size;
         ex_wdata    <= (issue_op == pipe_op_pkg::OP_COPY) ? rd1_data : issue_wdata;
         load_data1  <= rd1_data;
         load_data2  <= (issue_op == pipe_op_pkg::OP_LOAD2) ? rd2_data : '0;
      end
   end

   assign load_valid = ex_valid
                       && (ex_op == pipe_op_pkg::OP_LOAD || ex_op == pipe_op_pkg::OP_LOAD2);

endmodule

`default_nettype wire

//--- rtl/mem_stage.sv
`default_nettype none

module mem_stage (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          ex_valid,
   input  wire                          ex_wr1_v,
   input  wire                          ex_wr2_v,
   input  wire mem_access_pkg::addr_t   ex_wr1_addr,
   input  wire mem_access_pkg::addr_t   ex_wr2_addr,
   input  wire mem_access_pkg::size_t   ex_size,
   input  wire mem_access_pkg::data_t   ex_wdata,
   output logic                         me_valid,
   output logic                         me_wr1_v,
   output logic                         me_wr2_v,
   output mem_access_pkg::addr_t        me_wr1_addr,
   output mem_access_pkg::addr_t        me_wr2_addr,
   output mem_access_pkg::size_t        me_size,
   output mem_access_pkg::byte_en_t     wr1_en,
   output mem_access_pkg::byte_en_t     wr2_en,
   output mem_access_pkg::data_t        wr_data
);

   mem_access_pkg::byte_en_t size_mask;

   always_ff @(posedge clk) begin
      if (reset) begin
         me_valid <= 1'b0;
         me_wr1_v <= 1'b0;
         me_wr2_v <= 1'b0;
      end else begin
         me_valid <= ex_valid;
         me_wr1_v <= ex_wr1_v;
         me_wr2_v <= ex_wr2_v;
      end
   end

   always_ff @(posedge clk) begin
      me_wr1_addr <= ex_wr1_addr;
      me_wr2_addr <= ex_wr2_addr;
      me_size     <= ex_size;
      wr_data     <= ex_wdata;
   end

   // One enable bit per byte below the access size
   always_comb begin
      for (int i = 0; i < mem_access_pkg::BYTES_PER_WORD; i++) begin
         size_mask[i] = i < int'(me_size);
      end
   end

   assign wr1_en = (me_valid && me_wr1_v) ? size_mask : '0;
   assign wr2_en = (me_valid && me_wr2_v) ? size_mask : '0;

endmodule

`default_nettype wire

//--- rtl/mem_pipe_top.sv
`default_nettype none

module mem_pipe_top (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          in_valid,
   input  wire pipe_op_pkg::op_t        op,
   input  wire mem_access_pkg::addr_t   addr_a,
   input  wire mem_access_pkg::addr_t   addr_b,
   input  wire mem_access_pkg::size_t   size,
   input  wire mem_access_pkg::data_t   wdata,
   output wire                          in_ready,
   output wire                          load_valid,
   output wire mem_access_pkg::data_t   load_data1,
   output wire mem_access_pkg::data_t   load_data2
);

   logic                     stall;
   logic                     issue_valid;
   pipe_op_pkg::op_t         issue_op;
   logic                     rd1_v;
   logic                     rd2_v;
   logic                     wr1_v;
   logic                     wr2_v;
   mem_access_pkg::addr_t    rd1_addr;
   mem_access_pkg::addr_t    rd2_addr;
   mem_access_pkg::addr_t    wr1_addr;
   mem_access_pkg::addr_t    wr2_addr;
   mem_access_pkg::size_t    issue_size;
   mem_access_pkg::data_t    issue_wdata;
   mem_access_pkg::data_t    rd1_data;
   mem_access_pkg::data_t    rd2_data;

   logic                     ex_valid;
   logic                     ex_wr1_v;
   logic                     ex_wr2_v;
   mem_access_pkg::addr_t    ex_wr1_addr;
   mem_access_pkg::addr_t    ex_wr2_addr;
   mem_access_pkg::size_t    ex_size;
   mem_access_pkg::data_t    ex_wdata;

   logic                     me_valid;
   logic                     me_wr1_v;
   logic                     me_wr2_v;
   mem_access_pkg::addr_t    me_wr1_addr;
   mem_access_pkg::addr_t    me_wr2_addr;
   mem_access_pkg::size_t    me_size;
   mem_access_pkg::byte_en_t wr1_en;
   mem_access_pkg::byte_en_t wr2_en;
   mem_access_pkg::data_t    wr_data;

   ////////////////////
   // Issue and hazard check

   issue_stage issue_stage_i (
      .clk(clk), .reset(reset), .in_valid(in_valid), .op(op),
      .addr_a(addr_a), .addr_b(addr_b), .size(size), .wdata(wdata),
      .stall(stall), .in_ready(in_ready), .issue_valid(issue_valid),
      .issue_op(issue_op), .rd1_v(rd1_v), .rd2_v(rd2_v), .wr1_v(wr1_v), .wr2_v(wr2_v),
      .rd1_addr(rd1_addr), .rd2_addr(rd2_addr), .wr1_addr(wr1_addr),
      .wr2_addr(wr2_addr), .issue_size(issue_size), .issue_wdata(issue_wdata)
   );

   mem_dependency_check mem_dependency_check_i (
      .issue_valid(issue_valid), .rd1_v(rd1_v), .rd2_v(rd2_v),
      .rd1_addr(rd1_addr), .rd2_addr(rd2_addr), .rd_size(issue_size),
      .ex_valid(ex_valid), .ex_wr1_v(ex_wr1_v), .ex_wr2_v(ex_wr2_v),
      .ex_wr1_addr(ex_wr1_addr), .ex_wr2_addr(ex_wr2_addr), .ex_size(ex_size),
      .me_valid(me_valid), .me_wr1_v(me_wr1_v), .me_wr2_v(me_wr2_v),
      .me_wr1_addr(me_wr1_addr), .me_wr2_addr(me_wr2_addr), .me_size(me_size),
      .stall(stall)
   );

   // Reads come from the instruction in issue, writes from the memory stage
   byte_mem byte_mem_i (
      .clk(clk), .reset(reset),
      .rd1_addr(rd1_addr), .rd2_addr(rd2_addr), .rd_size(issue_size),
      .rd1_data(rd1_data), .rd2_data(rd2_data),
      .wr1_en(wr1_en), .wr2_en(wr2_en), .wr1_addr(me_wr1_addr), .wr2_addr(me_wr2_addr),
      .wr1_data(wr_data), .wr2_data(wr_data)
   );

   ////////////////////
   // Execute and memory stages

   exec_stage exec_stage_i (
      .clk(clk), .reset(reset), .issue_valid(issue_valid), .stall(stall),
      .issue_op(issue_op), .wr1_v(wr1_v), .wr2_v(wr2_v),
      .wr1_addr(wr1_addr), .wr2_addr(wr2_addr), .issue_size(issue_size),
      .issue_wdata(issue_wdata), .rd1_data(rd1_data), .rd2_data(rd2_data),
      .ex_valid(ex_valid), .ex_wr1_v(ex_wr1_v), .ex_wr2_v(ex_wr2_v),
      .ex_wr1_addr(ex_wr1_addr), .ex_wr2_addr(ex_wr2_addr), .ex_size(ex_size),
      .ex_wdata(ex_wdata), .load_valid(load_valid),
      .load_data1(load_data1), .load_data2(load_data2)
   );

   mem_stage mem_stage_i (
      .clk(clk), .reset(reset), .ex_valid(ex_valid),
      .ex_wr1_v(ex_wr1_v), .ex_wr2_v(ex_wr2_v),
      .ex_wr1_addr(ex_wr1_addr), .ex_wr2_addr(ex_wr2_addr),
      .ex_size(ex_size), .ex_wdata(ex_wdata),
      .me_valid(me_valid), .me_wr1_v(me_wr1_v), .me_wr2_v(me_wr2_v),
      .me_wr1_addr(me_wr1_addr), .me_wr2_addr(me_wr2_addr), .me_size(me_size),
      .wr1_en(wr1_en), .wr2_en(wr2_en), .wr_data(wr_data)
   );

endmodule

`default_nettype wire

//--- bench/mem_pipe_tb.sv
`default_nettype none

module mem_pipe_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 4;
   localparam int unsigned RAND_SEED = 32'hec1ac591;
   localparam int RANDOM_ENTRIES = 40;

   logic                  clk;
   logic                  reset;
   logic                  in_valid;
   pipe_op_pkg::op_t      op;
   mem_access_pkg::addr_t addr_a;
   mem_access_pkg::addr_t addr_b;
   mem_access_pkg::size_t size;
   mem_access_pkg::data_t wdata;
   logic                  in_ready;
   logic                  load_valid;
   mem_access_pkg::data_t load_data1;
   mem_access_pkg::data_t load_data2;

   // Stimulus table, one row per instruction
   string                 tbl_name  [$];
   int                    tbl_idle  [$];
   pipe_op_pkg::op_t      tbl_op    [$];
   mem_access_pkg::addr_t tbl_a     [$];
   mem_access_pkg::addr_t tbl_b     [$];
   mem_access_pkg::size_t tbl_size  [$];
   mem_access_pkg::data_t tbl_wdata [$];

   int                    exp_stall [$];
   mem_access_pkg::data_t exp_load1 [$];
   mem_access_pkg::data_t exp_load2 [$];
   string                 exp_load_name [$];
   int                    exp_loads_total;

   logic [7:0]            model_mem [mem_access_pkg::MEM_BYTES];

   bit                    table_ready;
   bit                    measuring;
   int                    stall_idx;
   int                    stall_run;
   int                    stall_checks;
   int                    accept_count;
   int                    loads_seen;
   int                    data_errors;
   int                    count_errors;
   int                    other_errors;

   mem_pipe_top mem_pipe_top_i (
      .clk(clk), .reset(reset), .in_valid(in_valid), .op(op),
      .addr_a(addr_a), .addr_b(addr_b), .size(size), .wdata(wdata),
      .in_ready(in_ready), .load_valid(load_valid),
      .load_data1(load_data1), .load_data2(load_data2)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////
   // Compare tasks

   task automatic check_data(input string name, input mem_access_pkg::data_t expected,
                             input mem_access_pkg::data_t actual);
      if (expected !== actual) begin
         $display("FAIL %s: expected %h, actual %h", name, expected, actual);
         data_errors++;
      end
   endtask

   task automatic check_count(input string name, input int expected, input int actual);
      if (expected != actual) begin
         $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
         count_errors++;
      end
   endtask

   ////////////////////
   // Reference model

   task automatic add_entry(input string name, input int idle, input pipe_op_pkg::op_t entry_op,
                            input mem_access_pkg::addr_t a, input mem_access_pkg::addr_t b,
                            input mem_access_pkg::size_t sz, input mem_access_pkg::data_t wd);
      tbl_name.push_back(name);
      tbl_idle.push_back(idle);
      tbl_op.push_back(entry_op);
      tbl_a.push_back(a);
      tbl_b.push_back(b);
      tbl_size.push_back(sz);
      tbl_wdata.push_back(wd);
   endtask

   function automatic mem_access_pkg::data_t model_read(input mem_access_pkg::addr_t addr,
                                                        input mem_access_pkg::size_t sz);
      mem_access_pkg::data_t word;
      word = '0;
      for (int i = 0; i < int'(sz); i++) begin
         word[8*i +: 8] = model_mem[mem_access_pkg::mem_idx_t'(addr + 32'(i))];
      end
      return word;
   endfunction

   task automatic model_write(input mem_access_pkg::addr_t addr, input mem_access_pkg::size_t sz,
                              input mem_access_pkg::data_t data);
      for (int i = 0; i < int'(sz); i++) begin
         model_mem[mem_access_pkg::mem_idx_t'(addr + 32'(i))] = data[8*i +: 8];
      end
   endtask

   function automatic bit ranges_overlap(input mem_access_pkg::addr_t a_start,
                                         input mem_access_pkg::size_t a_size,
                                         input mem_access_pkg::addr_t b_start,
                                         input mem_access_pkg::size_t b_size);
      longint a_end;
      longint b_end;
      a_end = longint'(a_start) + longint'(a_size);
      b_end = longint'(b_start) + longint'(b_size);
      return (longint'(a_start) < b_end) && (longint'(b_start) < a_end);
   endfunction

   // Read port 0 uses addr_a, port 1 uses addr_b
   function automatic bit reads_at(input int idx, input int port,
                                   output mem_access_pkg::addr_t addr);
      addr = (port == 0) ? tbl_a[idx] : tbl_b[idx];
      case (tbl_op[idx])
         pipe_op_pkg::OP_LOAD, pipe_op_pkg::OP_COPY: return port == 0;
         pipe_op_pkg::OP_LOAD2: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic bit writes_at(input int idx, input int port,
                                    output mem_access_pkg::addr_t addr);
      addr = (port == 0) ? tbl_a[idx] : tbl_b[idx];
      case (tbl_op[idx])
         pipe_op_pkg::OP_STORE: return port == 0;
         pipe_op_pkg::OP_STORE2: return 1'b1;
         pipe_op_pkg::OP_COPY: begin
            addr = tbl_b[idx];
            return port == 0;
         end
         default: return 1'b0;
      endcase
   endfunction

   function automatic bit reads_hit_writes(input int rd_idx, input int wr_idx);
      mem_access_pkg::addr_t ra;
      mem_access_pkg::addr_t wa;
      bit                    hit;
      hit = 1'b0;
      for (int r = 0; r < 2; r++) begin
         for (int w = 0; w < 2; w++) begin
            if (reads_at(rd_idx, r, ra) && writes_at(wr_idx, w, wa)
                  && ranges_overlap(ra, tbl_size[rd_idx], wa, tbl_size[wr_idx])) begin
               hit = 1'b1;
            end
         end
      end
      return hit;
   endfunction

   // Edge numbers relative to the first acceptance. A write is visible to the
   // check on the edge its instruction leaves issue and on the edge after
   task automatic predict_all();
      int                    accept_at [$];
      int                    leave_at  [$];
      int                    acc;
      int                    stall;
      mem_access_pkg::data_t copied;
      foreach (model_mem[i]) begin
         model_mem[i] = 8'h00;
      end
      exp_loads_total = 0;
      for (int j = 0; j < tbl_op.size(); j++) begin
         acc = 0;
         if (j > 0) begin
            acc = accept_at[j-1] + tbl_idle[j] + 1;
            if (leave_at[j-1] > acc) begin
               acc = leave_at[j-1];
            end
         end
         stall = 0;
         for (int k = 0; k < j; k++) begin
            if (reads_hit_writes(j, k) && (leave_at[k] + 2 - acc > stall)) begin
               stall = leave_at[k] + 2 - acc;
            end
         end
         accept_at.push_back(acc);
         leave_at.push_back(acc + 1 + stall);
         exp_stall.push_back(stall);
         case (tbl_op[j])
            pipe_op_pkg::OP_LOAD, pipe_op_pkg::OP_LOAD2: begin
               exp_load1.push_back(model_read(tbl_a[j], tbl_size[j]));
               if (tbl_op[j] == pipe_op_pkg::OP_LOAD2) begin
                  exp_load2.push_back(model_read(tbl_b[j], tbl_size[j]));
               end else begin
                  exp_load2.push_back('0);
               end
               exp_load_name.push_back(tbl_name[j]);
               exp_loads_total++;
            end
            pipe_op_pkg::OP_STORE: model_write(tbl_a[j], tbl_size[j], tbl_wdata[j]);
            pipe_op_pkg::OP_STORE2: begin
               model_write(tbl_a[j], tbl_size[j], tbl_wdata[j]);
               model_write(tbl_b[j], tbl_size[j], tbl_wdata[j]);
            end
            pipe_op_pkg::OP_COPY: begin
               copied = model_read(tbl_a[j], tbl_size[j]);
               model_write(tbl_b[j], tbl_size[j], copied);
            end
            default: ;
         endcase
      end
   endtask

   ////////////////////
   // Stimulus table

   task automatic build_table();
      add_entry("reset load8", 0, pipe_op_pkg::OP_LOAD, 32'h10, 32'h0, 4'd8, 64'h0);
      add_entry("reset load2 size3", 0, pipe_op_pkg::OP_LOAD2, 32'h20, 32'h30, 4'd3, 64'h0);
      add_entry("reset load1", 1, pipe_op_pkg::OP_LOAD, 32'h05, 32'h0, 4'd1, 64'h0);
      add_entry("store 0x40", 2, pipe_op_pkg::OP_STORE, 32'h40, 32'h0, 4'd8,
                64'h1122_3344_5566_7788);
      add_entry("load right after store", 0, pipe_op_pkg::OP_LOAD, 32'h44, 32'h0, 4'd4, 64'h0);
      add_entry("store 0x50", 0, pipe_op_pkg::OP_STORE, 32'h50, 32'h0, 4'd4, 64'ha1b2_c3d4);
      add_entry("nop between", 0, pipe_op_pkg::OP_NOP, 32'h0, 32'h0, 4'd1, 64'h0);
      add_entry("load2 one behind store", 0, pipe_op_pkg::OP_LOAD2, 32'h60, 32'h52, 4'd2, 64'h0);
      add_entry("prefill 0x84", 2, pipe_op_pkg::OP_STORE, 32'h84, 32'h0, 4'd8,
                64'hcafe_f00d_dead_beef);
      add_entry("store 0x80", 3, pipe_op_pkg::OP_STORE, 32'h80, 32'h0, 4'd4,
                64'h0102_0304_0506_0708);
      add_entry("load touching end", 0, pipe_op_pkg::OP_LOAD, 32'h84, 32'h0, 4'd4, 64'h0);
      add_entry("load2 touching both", 0, pipe_op_pkg::OP_LOAD2, 32'h7c, 32'h84, 4'd4, 64'h0);
      add_entry("store2 0x90 0x98", 1, pipe_op_pkg::OP_STORE2, 32'h90, 32'h98, 4'd2, 64'h5a5a);
      add_entry("load2 between writes", 0, pipe_op_pkg::OP_LOAD2, 32'h92, 32'h9a, 4'd6, 64'h0);
      add_entry("store2 overlapping", 2, pipe_op_pkg::OP_STORE2, 32'ha0, 32'ha2, 4'd4,
                64'haabb_ccdd);
      add_entry("load after store2", 3, pipe_op_pkg::OP_LOAD, 32'ha0, 32'h0, 4'd8, 64'h0);
      add_entry("copy 0xa0 to 0xc0", 0, pipe_op_pkg::OP_COPY, 32'ha0, 32'hc0, 4'd6, 64'h0);
      add_entry("load copied bytes", 0, pipe_op_pkg::OP_LOAD, 32'hbe, 32'h0, 4'd4, 64'h0);
      add_entry("load2 copied tail", 0, pipe_op_pkg::OP_LOAD2, 32'hc4, 32'ha4, 4'd2, 64'h0);

      // Random rows use a narrow address window so overlaps are common
      for (int r = 0; r < RANDOM_ENTRIES; r++) begin
         add_entry($sformatf("random %0d", r),
                   ($urandom_range(0, 3) == 0) ? 1 : 0,
                   pipe_op_pkg::op_t'($urandom_range(0, 5)),
                   mem_access_pkg::addr_t'(32'h40 + $urandom_range(0, 23)),
                   mem_access_pkg::addr_t'(32'h40 + $urandom_range(0, 23)),
                   mem_access_pkg::size_t'($urandom_range(1, 8)),
                   {$urandom, $urandom});
      end
   endtask

   ////////////////////
   // Stall and load monitor

   always @(negedge clk) begin
      if (!reset) begin
         if (measuring && !in_ready) begin
            stall_run++;
         end else if (measuring) begin
            check_count({tbl_name[stall_idx], " stall"}, exp_stall[stall_idx], stall_run);
            measuring = 1'b0;
            stall_checks++;
         end
         if (in_valid && in_ready) begin
            measuring = 1'b1;
            stall_idx = accept_count;
            stall_run = 0;
            accept_count++;
         end
         if (load_valid) begin
            loads_seen++;
            if (exp_load1.size() == 0) begin
               $display("Unexpected load_valid pulse with no load outstanding at %0t", $time);
               other_errors++;
            end else begin
               check_data({exp_load_name[0], " data1"}, exp_load1[0], load_data1);
               check_data({exp_load_name[0], " data2"}, exp_load2[0], load_data2);
               exp_load1.delete(0);
               exp_load2.delete(0);
               exp_load_name.delete(0);
            end
         end
      end
   end

   initial begin
      wait (table_ready);
      #(CLK_PERIOD * (tbl_op.size() * 8 + 50));
      $display("Watchdog timeout after %0d clock periods", tbl_op.size() * 8 + 50);
      $display("SIMULATION FAILED");
      $finish;
   end

   initial begin
      logic ready_seen;
      void'($urandom(RAND_SEED));
      clk      = 1'b0;
      reset    = 1'b1;
      in_valid = 1'b0;
      op       = pipe_op_pkg::OP_NOP;
      addr_a   = '0;
      addr_b   = '0;
      size     = '0;
      wdata    = '0;
      build_table();
      predict_all();
      table_ready = 1'b1;

      repeat (4) @(posedge clk);
      reset <= 1'b0;

      for (int i = 0; i < tbl_op.size(); i++) begin
         if (tbl_idle[i] > 0) begin
            in_valid <= 1'b0;
            repeat (tbl_idle[i]) @(posedge clk);
         end
         in_valid <= 1'b1;
         op       <= tbl_op[i];
         addr_a   <= tbl_a[i];
         addr_b   <= tbl_b[i];
         size     <= tbl_size[i];
         wdata    <= tbl_wdata[i];
         // Hold until an edge with in_ready high
         do begin
            @(negedge clk);
            ready_seen = in_ready;
            @(posedge clk);
         end while (ready_seen !== 1'b1);
      end
      in_valid <= 1'b0;

      wait (stall_checks == tbl_op.size());
      repeat (4) @(posedge clk);
      check_count("load_valid pulses", exp_loads_total, loads_seen);
      if (exp_load1.size() != 0) begin
         $display("%0d expected load results never appeared", exp_load1.size());
         other_errors++;
      end
      $display("Errors: data %0d, count %0d, other %0d over %0d instructions",
               data_errors, count_errors, other_errors, tbl_op.size());
      if (data_errors + count_errors + other_errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
rtl/mem_access_pkg.sv
rtl/pipe_op_pkg.sv
rtl/issue_stage.sv
rtl/mem_dependency_check.sv
rtl/byte_mem.sv
rtl/exec_stage.sv
rtl/mem_stage.sv
rtl/mem_pipe_top.sv
bench/mem_pipe_tb.sv

//--- run.sh
#!/bin/sh
# Compile the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module mem_pipe_tb -f src.f -o mem_pipe_sim

result=$(./obj_dir/mem_pipe_sim)
echo "$result"

if echo "$result" | grep -q "SIMULATION PASSED"; then
   exit 0
fi
exit 1
